// File: source/conv_pkg.sv
package conv_pkg;

  // kernel geometry
  localparam int TAP_COUNT = 9;

  // leaves of the adder tree, tap count rounded up to a power of two
  localparam int MA_TREE_SIZE = 16;
  localparam int TREE_DEPTH = $clog2(MA_TREE_SIZE);

  // datapath widths
  localparam int PIXEL_WIDTH = 8;
  localparam int WEIGHT_WIDTH = 8;
  localparam int PRODUCT_WIDTH = PIXEL_WIDTH + WEIGHT_WIDTH;

  // headroom for summing the products up the tree
  localparam int PAD_WIDTH = 4;
  localparam int ACC_WIDTH = PRODUCT_WIDTH + PAD_WIDTH;

  localparam int RESULT_WIDTH = 16;
  localparam int TAP_INDEX_WIDTH = 4;

  typedef logic signed [PIXEL_WIDTH-1:0] pixel_t;

  typedef logic signed [WEIGHT_WIDTH-1:0] weight_t;

  typedef logic signed [PRODUCT_WIDTH-1:0] product_t;

  // product sign extended by the pad bits
  typedef logic signed [ACC_WIDTH-1:0] acc_t;

  typedef logic signed [RESULT_WIDTH-1:0] result_t;

  typedef logic [TAP_INDEX_WIDTH-1:0] tap_index_t;

endpackage

// File: source/kernel_loader.sv
module kernel_loader (
  input  logic                                         clock,
  input  logic                                         reset,
  input  conv_pkg::weight_t                            weight_in,
  input  conv_pkg::tap_index_t                         weight_addr,
  input  logic                                         weight_strobe,
  output conv_pkg::weight_t [conv_pkg::TAP_COUNT-1:0]  taps
);

  conv_pkg::weight_t weights [conv_pkg::TAP_COUNT];
  logic              addr_in_range;

  // addresses past the last tap are dropped
  assign addr_in_range =
    (weight_addr < conv_pkg::TAP_INDEX_WIDTH'(conv_pkg::TAP_COUNT));

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      weights <= '{default: '0};
    end else if (weight_strobe && addr_in_range) begin
      weights[weight_addr] <= weight_in;
    end
  end

  // taps follow the registers directly, tap 0 in the low byte
  genvar t;
  generate
    for (t = 0; t < conv_pkg::TAP_COUNT; t++) begin : g_tap
      assign taps[t] = weights[t];
    end
  endgenerate

endmodule

// File: source/window_shifter.sv
module window_shifter #(
  parameter int image_width = 8
) (
  input  logic                                        clock,
  input  logic                                        reset,
  input  conv_pkg::pixel_t                            pixel_in,
  input  logic                                        pixel_strobe,
  output conv_pkg::pixel_t [conv_pkg::TAP_COUNT-1:0]  window,
  output logic                                        window_valid
);

  localparam int WINDOW_DIM = 3;
  localparam int COL_WIDTH = (image_width > 1) ? $clog2(image_width) : 1;

  typedef enum logic {
    fill_rows,
    streaming
  } fill_state_t;

  fill_state_t state;

  logic [COL_WIDTH-1:0] col;
  logic [1:0]           row;
  logic                 last_col;
  logic                 window_done;

  // row delays, near holds the previous row and far the one before it
  conv_pkg::pixel_t line_near [image_width];
  conv_pkg::pixel_t line_far  [image_width];
  conv_pkg::pixel_t near_out;
  conv_pkg::pixel_t far_out;

  // window storage as [row][column], column 2 is the newest
  conv_pkg::pixel_t win [WINDOW_DIM][WINDOW_DIM];

  assign near_out = line_near[col];
  assign far_out  = line_far[col];

  assign last_col = (col == COL_WIDTH'(image_width - 1));

  // third pixel of the third row completes the first window
  assign window_done = (row == 2'd2) && (col >= COL_WIDTH'(WINDOW_DIM - 1));

  // read before write at the same column
  always_ff @(posedge clock) begin
    if (pixel_strobe) begin
      line_far[col]  <= near_out;
      line_near[col] <= pixel_in;
    end
  end

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      win <= '{default: '0};
    end else if (pixel_strobe) begin
      for (int r = 0; r < WINDOW_DIM; r++) begin
        win[r][0] <= win[r][1];
        win[r][1] <= win[r][2];
      end
      win[0][2] <= far_out;
      win[1][2] <= near_out;
      win[2][2] <= pixel_in;
    end
  end

  // column and row counters with the fill state
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      col          <= '0;
      row          <= '0;
      state        <= fill_rows;
      window_valid <= 1'b0;
    end else begin
      window_valid <= 1'b0;
      if (pixel_strobe) begin
        col <= last_col ? '0 : col + 1'b1;
        // row count saturates once two rows are stored
        if (last_col && (row != 2'd2)) begin
          row <= row + 1'b1;
        end
        case (state)
          fill_rows: begin
            if (window_done) begin
              state        <= streaming;
              window_valid <= 1'b1;
            end
          end
          streaming: begin
            window_valid <= 1'b1;
          end
          default: begin
            state <= fill_rows;
          end
        endcase
      end
    end
  end

  // raster order, tap 0 is top-left
  genvar r, c;
  generate
    for (r = 0; r < WINDOW_DIM; r++) begin : g_row
      for (c = 0; c < WINDOW_DIM; c++) begin : g_col
        assign window[r * WINDOW_DIM + c] = win[r][c];
      end
    end
  endgenerate

endmodule

// File: source/mult_adder.sv
module mult_adder (
  input  logic                                         clock,
  input  logic                                         reset,
  input  conv_pkg::pixel_t  [conv_pkg::TAP_COUNT-1:0]  in,
  input  conv_pkg::weight_t [conv_pkg::TAP_COUNT-1:0]  kernel,
  output conv_pkg::acc_t                               sum,
  output logic                                         carry
);

  localparam int NODE_COUNT  = 2 * conv_pkg::MA_TREE_SIZE - 1;
  localparam int LEAF_BASE   = conv_pkg::MA_TREE_SIZE - 1;
  localparam int PRODUCT_MSB = conv_pkg::PRODUCT_WIDTH - 1;
  localparam int ACC_MSB     = conv_pkg::ACC_WIDTH - 1;

  // heap order, node 0 is the root and node n has children 2n+1 and 2n+2
  conv_pkg::acc_t tree       [NODE_COUNT];
  logic           tree_carry [NODE_COUNT];

  genvar i;
  generate
    for (i = 0; i < conv_pkg::MA_TREE_SIZE; i++) begin : g_leaf
      if (i < conv_pkg::TAP_COUNT) begin : g_tap
        conv_pkg::product_t product;

        // one registered multiply per tap
        always_ff @(posedge clock or negedge reset) begin
          if (!reset) begin
            product <= '0;
          end else begin
            product <= $signed(in[i]) * $signed(kernel[i]);
          end
        end

        assign tree[LEAF_BASE + i] = {{conv_pkg::PAD_WIDTH{product[PRODUCT_MSB]}}, product};
      end else begin : g_unused
        // spare leaves above the last tap
        assign tree[LEAF_BASE + i] = '0;
      end

      assign tree_carry[LEAF_BASE + i] = 1'b0;
    end
  endgenerate

  genvar n;
  generate
    for (n = 0; n < LEAF_BASE; n++) begin : g_node
      conv_pkg::acc_t operand_a;
      conv_pkg::acc_t operand_b;
      conv_pkg::acc_t next_sum;
      logic           next_overflow;
      conv_pkg::acc_t node_sum;
      logic           node_carry;

      assign operand_a = tree[2 * n + 1];
      assign operand_b = tree[2 * n + 2];
      assign next_sum  = operand_a + operand_b;

      // signed overflow when both operands agree in sign and the sum does not
      assign next_overflow = (operand_a[ACC_MSB] == operand_b[ACC_MSB]) &&
                             (next_sum[ACC_MSB] != operand_a[ACC_MSB]);

      always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
          node_sum   <= '0;
          node_carry <= 1'b0;
        end else begin
          node_sum   <= next_sum;
          // sticky, carries from either child ride along with the sum
          node_carry <= next_overflow | tree_carry[2 * n + 1] | tree_carry[2 * n + 2];
        end
      end

      assign tree[n]       = node_sum;
      assign tree_carry[n] = node_carry;
    end
  endgenerate

  assign sum   = tree[0];
  assign carry = tree_carry[0];

endmodule

// File: source/conv_result.sv
module conv_result (
  input  logic              clock,
  input  logic              reset,
  input  conv_pkg::acc_t    sum,
  input  logic              carry,
  input  logic              tree_valid,
  input  conv_pkg::result_t bias_in,
  input  logic              relu_enable,
  output conv_pkg::result_t result_out,
  output logic              result_valid,
  output logic              overflow
);

  // one extra bit so the bias add cannot wrap
  localparam int WIDE = conv_pkg::ACC_WIDTH + 1;

  localparam logic signed [WIDE-1:0] SAT_HIGH =
    WIDE'((2 ** (conv_pkg::RESULT_WIDTH - 1)) - 1);
  localparam logic signed [WIDE-1:0] SAT_LOW = -SAT_HIGH - 1;

  logic signed [WIDE-1:0] sum_wide;
  logic signed [WIDE-1:0] bias_wide;
  logic signed [WIDE-1:0] biased;
  logic signed [WIDE-1:0] rectified;
  conv_pkg::result_t      saturated;
  logic                   clipped;

  assign sum_wide  = {sum[conv_pkg::ACC_WIDTH-1], sum};
  assign bias_wide = {{(WIDE - conv_pkg::RESULT_WIDTH){bias_in[conv_pkg::RESULT_WIDTH-1]}},
                      bias_in};
  assign biased    = sum_wide + bias_wide;

  // relu clamps negative sums to zero
  assign rectified = (relu_enable && biased[WIDE-1]) ? '0 : biased;

  always_comb begin
    clipped   = 1'b0;
    saturated = rectified[conv_pkg::RESULT_WIDTH-1:0];
    if (rectified > SAT_HIGH) begin
      clipped   = 1'b1;
      saturated = SAT_HIGH[conv_pkg::RESULT_WIDTH-1:0];
    end else if (rectified < SAT_LOW) begin
      clipped   = 1'b1;
      saturated = SAT_LOW[conv_pkg::RESULT_WIDTH-1:0];
    end
  end

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      result_out   <= '0;
      result_valid <= 1'b0;
      overflow     <= 1'b0;
    end else begin
      result_out   <= saturated;
      result_valid <= tree_valid;
      // flagged only alongside a valid result
      overflow     <= tree_valid && (carry || clipped);
    end
  end

endmodule

// File: source/conv_engine.sv
module conv_engine #(
  parameter int image_width = 8
) (
  input  logic                 clock,
  input  logic                 reset,
  input  conv_pkg::pixel_t     pixel_in,
  input  logic                 pixel_strobe,
  input  conv_pkg::weight_t    weight_in,
  input  conv_pkg::tap_index_t weight_addr,
  input  logic                 weight_strobe,
  input  conv_pkg::result_t    bias_in,
  input  logic                 relu_enable,
  output conv_pkg::result_t    result_out,
  output logic                 result_valid,
  output logic                 overflow
);

  // multiply stage plus one stage per tree level
  localparam int VALID_DELAY = 1 + conv_pkg::TREE_DEPTH;

  conv_pkg::weight_t [conv_pkg::TAP_COUNT-1:0] taps;
  conv_pkg::pixel_t  [conv_pkg::TAP_COUNT-1:0] window;
  logic                                        window_valid;
  conv_pkg::acc_t                              sum;
  logic                                        carry;
  logic [VALID_DELAY-1:0]                      valid_pipe;
  logic                                        tree_valid;

  kernel_loader kernel_loader_inst (
    .clock         (clock),
    .reset         (reset),
    .weight_in     (weight_in),
    .weight_addr   (weight_addr),
    .weight_strobe (weight_strobe),
    .taps          (taps)
  );

  window_shifter #(
    .image_width (image_width)
  ) window_shifter_inst (
    .clock        (clock),
    .reset        (reset),
    .pixel_in     (pixel_in),
    .pixel_strobe (pixel_strobe),
    .window       (window),
    .window_valid (window_valid)
  );

  mult_adder mult_adder_inst (
    .clock  (clock),
    .reset  (reset),
    .in     (window),
    .kernel (taps),
    .sum    (sum),
    .carry  (carry)
  );

  // track each window through the tree
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[VALID_DELAY-2:0], window_valid};
    end
  end

  assign tree_valid = valid_pipe[VALID_DELAY-1];

  conv_result conv_result_inst (
    .clock        (clock),
    .reset        (reset),
    .sum          (sum),
    .carry        (carry),
    .tree_valid   (tree_valid),
    .bias_in      (bias_in),
    .relu_enable  (relu_enable),
    .result_out   (result_out),
    .result_valid (result_valid),
    .overflow     (overflow)
  );

endmodule

// File: dv/conv_engine_tb.sv
module conv_engine_tb;

  localparam int IMAGE_WIDTH = 8;
  localparam int LATENCY = 7;
  localparam int DRAIN_LIMIT = 200;

  logic                 clock;
  logic                 reset;
  conv_pkg::pixel_t     pixel_in;
  logic                 pixel_strobe;
  conv_pkg::weight_t    weight_in;
  conv_pkg::tap_index_t weight_addr;
  logic                 weight_strobe;
  conv_pkg::result_t    bias_in;
  logic                 relu_enable;
  conv_pkg::result_t    result_out;
  logic                 result_valid;
  logic                 overflow;

  // reference model, frame in raster order and the current kernel
  int frame_q[$];
  int kernel_model[conv_pkg::TAP_COUNT];
  int expected_value_q[$];
  bit expected_ovf_q[$];
  int expected_cycle_q[$];

  int cycle_count = 0;
  int error_count = 0;
  int check_count = 0;
  int test_count = 0;
  int test_error_base = 0;
  int results_seen = 0;
  int overflow_seen = 0;
  int first_result_cycle = 0;
  int last_result_cycle = 0;

  conv_engine #(
    .image_width (IMAGE_WIDTH)
  ) conv_engine_inst (
    .clock         (clock),
    .reset         (reset),
    .pixel_in      (pixel_in),
    .pixel_strobe  (pixel_strobe),
    .weight_in     (weight_in),
    .weight_addr   (weight_addr),
    .weight_strobe (weight_strobe),
    .bias_in       (bias_in),
    .relu_enable   (relu_enable),
    .result_out    (result_out),
    .result_valid  (result_valid),
    .overflow      (overflow)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
  end

  // outputs change on the rising edge, so they are read on the falling one
  always @(negedge clock) begin : monitor
    int exp_value;
    bit exp_ovf;
    int exp_cycle;
    if (reset && result_valid) begin
      if (results_seen == 0) begin
        first_result_cycle = cycle_count;
      end
      last_result_cycle = cycle_count;
      results_seen++;
      if (overflow) begin
        overflow_seen++;
      end
      assert (expected_value_q.size() > 0) else begin
        error_count++;
        $display("result_valid pulsed at cycle %0d with no window pending", cycle_count);
      end
      if (expected_value_q.size() > 0) begin
        exp_value = expected_value_q.pop_front();
        exp_ovf = expected_ovf_q.pop_front();
        exp_cycle = expected_cycle_q.pop_front();
        check_count++;
        assert (int'(result_out) == exp_value) else begin
          error_count++;
          $display("CHECK FAILED result_out: got %h expected %h", result_out, 16'(exp_value));
        end
        assert (overflow == exp_ovf) else begin
          error_count++;
          $display("CHECK FAILED overflow: got %h expected %h", overflow, exp_ovf);
        end
        assert (cycle_count == exp_cycle) else begin
          error_count++;
          $display("result arrived at cycle %0d but was due at cycle %0d",
                   cycle_count, exp_cycle);
        end
      end
    end else if (reset) begin
      assert (!overflow) else begin
        error_count++;
        $display("overflow pulsed at cycle %0d without result_valid", cycle_count);
      end
    end
  end

  // windows per frame, the first one completes at the third pixel of row 2
  function automatic int windows_in_frame(input int rows);
    return (rows - 2) * IMAGE_WIDTH - 2;
  endfunction

  function automatic int random_in(input int lo, input int hi);
    return lo + int'($urandom % (hi - lo + 1));
  endfunction

  // 3x3 dot product of the window that pixel k completes
  function automatic int window_dot(input int k);
    int acc;
    acc = 0;
    for (int r = 0; r < 3; r++) begin
      for (int c = 0; c < 3; c++) begin
        acc += frame_q[k - (2 - r) * IMAGE_WIDTH - (2 - c)] * kernel_model[r * 3 + c];
      end
    end
    return acc;
  endfunction

  // bias, relu and 16-bit saturation; the tree sum never leaves 20 bits
  task automatic push_expected(input int acc);
    int value;
    bit ovf;
    value = acc + int'(bias_in);
    ovf = 1'b0;
    if (relu_enable && value < 0) begin
      value = 0;
    end
    if (value > 32767) begin
      value = 32767;
      ovf = 1'b1;
    end else if (value < -32768) begin
      value = -32768;
      ovf = 1'b1;
    end
    expected_value_q.push_back(value);
    expected_ovf_q.push_back(ovf);
    expected_cycle_q.push_back(cycle_count + LATENCY);
  endtask

  task automatic apply_reset(input int bias, input bit relu);
    reset = 1'b0;
    pixel_strobe = 1'b0;
    weight_strobe = 1'b0;
    bias_in = conv_pkg::result_t'(bias);
    relu_enable = relu;
    frame_q.delete();
    // windows still in the pipeline are lost with the reset
    expected_value_q.delete();
    expected_ovf_q.delete();
    expected_cycle_q.delete();
    foreach (kernel_model[t]) begin
      kernel_model[t] = 0;
    end
    repeat (8) begin
      @(negedge clock);
      assert (!result_valid && !overflow) else begin
        error_count++;
        $display("result_valid or overflow high while reset is held");
      end
    end
    reset = 1'b1;
  endtask

  task automatic write_weight(input int addr, input int value);
    weight_addr = conv_pkg::tap_index_t'(addr);
    weight_in = conv_pkg::weight_t'(value);
    weight_strobe = 1'b1;
    if (addr < conv_pkg::TAP_COUNT) begin
      kernel_model[addr] = value;
    end
    @(negedge clock);
    weight_strobe = 1'b0;
  endtask

  task automatic feed_pixel(input int value);
    int k;
    k = frame_q.size();
    frame_q.push_back(value);
    pixel_in = conv_pkg::pixel_t'(value);
    pixel_strobe = 1'b1;
    if (k >= 2 * IMAGE_WIDTH + 2) begin
      push_expected(window_dot(k));
    end
    @(negedge clock);
    pixel_strobe = 1'b0;
  endtask

  // random pixels with random idle cycles between strobes
  task automatic feed_frame(input int rows, input int lo, input int hi, input int max_gap);
    for (int i = 0; i < rows * IMAGE_WIDTH; i++) begin
      feed_pixel(random_in(lo, hi));
      repeat (random_in(0, max_gap)) @(negedge clock);
    end
  endtask

  task automatic start_test();
    test_error_base = error_count;
    results_seen = 0;
    overflow_seen = 0;
  endtask

  task automatic finish_test(input string name, input int expected_results);
    int waited;
    waited = 0;
    while (expected_value_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(negedge clock);
      waited++;
    end
    assert (expected_value_q.size() == 0) else begin
      error_count++;
      $display("timeout in %s, %0d results never arrived", name, expected_value_q.size());
    end
    expected_value_q.delete();
    expected_ovf_q.delete();
    expected_cycle_q.delete();
    // room for a late or extra pulse
    repeat (LATENCY + 2) @(negedge clock);
    assert (results_seen == expected_results) else begin
      error_count++;
      $display("CHECK FAILED results_seen: got %h expected %h", results_seen, expected_results);
    end
    test_count++;
    $display("test %s finished: %0d results, %0d errors", name, results_seen,
             error_count - test_error_base);
  endtask

  task automatic identity_kernel_test();
    start_test();
    apply_reset(0, 1'b0);
    write_weight(4, 1);
    // ramp crossing zero
    for (int i = 0; i < 4 * IMAGE_WIDTH; i++) begin
      feed_pixel(3 * i - 48);
    end
    finish_test("identity_kernel", windows_in_frame(4));
  endtask

  task automatic random_kernel_test();
    start_test();
    apply_reset(0, 1'b0);
    for (int t = 0; t < conv_pkg::TAP_COUNT; t++) begin
      write_weight(t, random_in(-60, 60));
    end
    // 9 * 60 * 60 stays inside 16 bits
    feed_frame(5, -60, 60, 2);
    finish_test("random_kernel", windows_in_frame(5));
    assert (overflow_seen == 0) else begin
      error_count++;
      $display("overflow pulsed %0d times on a frame that cannot saturate", overflow_seen);
    end
  endtask

  task automatic bias_relu_test();
    for (int pass = 0; pass < 2; pass++) begin
      start_test();
      apply_reset(400, pass == 0);
      for (int t = 0; t < conv_pkg::TAP_COUNT; t++) begin
        write_weight(t, -3);
      end
      feed_frame(4, 0, 40, 1);
      finish_test(pass == 0 ? "bias_relu_on" : "bias_relu_off", windows_in_frame(4));
    end
  endtask

  task automatic saturation_test();
    start_test();
    apply_reset(0, 1'b0);
    for (int t = 0; t < conv_pkg::TAP_COUNT; t++) begin
      write_weight(t, -128);
    end
    feed_frame(3, -128, -128, 0);
    finish_test("saturation", windows_in_frame(3));
    assert (overflow_seen == results_seen) else begin
      error_count++;
      $display("CHECK FAILED overflow_seen: got %h expected %h", overflow_seen, results_seen);
    end
  endtask

  task automatic throughput_test();
    start_test();
    apply_reset(-25, 1'b0);
    for (int t = 0; t < conv_pkg::TAP_COUNT; t++) begin
      write_weight(t, random_in(-60, 60));
    end
    feed_frame(5, -60, 60, 0);
    finish_test("throughput", windows_in_frame(5));
    assert (last_result_cycle - first_result_cycle + 1 == results_seen) else begin
      error_count++;
      $display("results were not back to back, %0d results over cycles %0d to %0d",
               results_seen, first_result_cycle, last_result_cycle);
    end
  endtask

  task automatic kernel_rewrite_test();
    start_test();
    apply_reset(10, 1'b0);
    for (int t = 0; t < conv_pkg::TAP_COUNT; t++) begin
      write_weight(t, random_in(-60, 60));
    end
    feed_frame(3, -60, 60, 1);
    finish_test("kernel_before_rewrite", windows_in_frame(3));
    // more windows of the first frame, still in the tree when reset hits
    for (int i = 0; i < 4; i++) begin
      feed_pixel(random_in(-60, 60));
    end
    start_test();
    apply_reset(10, 1'b0);
    for (int t = 0; t < conv_pkg::TAP_COUNT; t++) begin
      write_weight(t, random_in(-60, 60));
    end
    // addresses past tap 8 leave the kernel alone
    write_weight(9, 55);
    write_weight(15, -1);
    for (int i = 0; i < 3 * IMAGE_WIDTH; i++) begin
      if (i == 20) begin
        write_weight(4, -7);
      end
      feed_pixel(random_in(-60, 60));
    end
    finish_test("kernel_after_rewrite", windows_in_frame(3));
  endtask

  initial begin
    reset = 1'b0;
    pixel_in = '0;
    pixel_strobe = 1'b0;
    weight_in = '0;
    weight_addr = '0;
    weight_strobe = 1'b0;
    bias_in = '0;
    relu_enable = 1'b0;
    void'($urandom(32'h3c2ed7ff));

    identity_kernel_test();
    random_kernel_test();
    bias_relu_test();
    saturation_test();
    throughput_test();
    kernel_rewrite_test();

    $display("%0d tests, %0d result checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: src.f
source/conv_pkg.sv
source/kernel_loader.sv
source/window_shifter.sv
source/mult_adder.sv
source/conv_result.sv
source/conv_engine.sv
dv/conv_engine_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the convolution engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module conv_engine_tb -f src.f -o conv_engine_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/conv_engine_sim > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "SIMULATION PASSED" "$log"; then
  exit 0
fi
echo "pass message not found in $log"
exit 1
